/* list.f */
rtl/dma_read_pkg.sv
rtl/dma_burst_planner.sv
rtl/axi_burst_reader.sv
rtl/sync_fifo.sv
rtl/fifo_to_stream.sv
rtl/dma_read.sv
sim/axi_mem_model.sv
sim/tb_dma_read.sv

/* rtl/axi_burst_reader.sv */
module axi_burst_reader (
   input  logic                            clk_i,
   input  logic                            reset_i,
   input  logic                            burst_start_i,
   input  logic [dma_read_pkg::ADDR_W-1:0] burst_addr_i,
   input  logic [dma_read_pkg::LVL_W-1:0]  burst_len_i,
   output logic                            busy_o,
   output dma_read_pkg::axi_ar_t           ar_o,
   output logic                            ar_valid_o,
   input  logic                            ar_ready_i,
   input  dma_read_pkg::axi_r_t            r_i,
   input  logic                            r_valid_i,
   output logic                            r_ready_o,
   input  logic                            fifo_full_i,
   output logic                            fifo_wen_o,
   output logic [dma_read_pkg::DATA_W-1:0] fifo_wdata_o
);

   typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_t;

   state_t                         state_q;
   dma_read_pkg::axi_ar_t          ar_q;
   logic [dma_read_pkg::LVL_W-1:0] len_m1;

   // AXI len field is beats minus one
   assign len_m1 = burst_len_i - 1'b1;

   assign busy_o     = (state_q != S_IDLE);
   assign ar_o       = ar_q;
   assign ar_valid_o = (state_q == S_ADDR);

   // Space was reserved up front, so this never actually stalls
   assign r_ready_o    = (state_q == S_DATA) && !fifo_full_i;
   assign fifo_wen_o   = r_valid_i && r_ready_o;
   assign fifo_wdata_o = r_i.data;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= S_IDLE;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (burst_start_i) begin
                  state_q <= S_ADDR;
               end
            end
            S_ADDR: begin
               if (ar_ready_i) begin
                  state_q <= S_DATA;
               end
            end
            default: begin
               if (fifo_wen_o && r_i.last) begin
                  state_q <= S_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (burst_start_i) begin
         ar_q.addr <= burst_addr_i;
         ar_q.len  <= len_m1[dma_read_pkg::LEN_W-1:0];
      end
   end

   assert property (@(posedge clk_i) disable iff (reset_i)
      ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o));

   // Planner must wait for the previous burst to finish
   assert property (@(posedge clk_i) disable iff (reset_i)
      busy_o |-> !burst_start_i);

endmodule

/* rtl/dma_burst_planner.sv */
module dma_burst_planner (
   input  logic                            clk_i,
   input  logic                            reset_i,
   input  logic                            start_i,
   input  logic [dma_read_pkg::ADDR_W-1:0] addr_i,
   input  logic [dma_read_pkg::RLEN_W-1:0] length_i,
   input  logic [dma_read_pkg::LVL_W-1:0]  max_len_i,
   input  logic [dma_read_pkg::LVL_W-1:0]  fifo_level_i,
   input  logic                            reader_busy_i,
   output logic                            burst_start_o,
   output logic [dma_read_pkg::ADDR_W-1:0] burst_addr_o,
   output logic [dma_read_pkg::LVL_W-1:0]  burst_len_o,
   output logic                            busy_o,
   output logic [dma_read_pkg::RLEN_W-1:0] remaining_o
);

   typedef enum logic {S_IDLE, S_WAIT_SPACE} state_t;

   state_t                          state_q;
   state_t                          state_d;
   logic [dma_read_pkg::RLEN_W-1:0] remaining_d;
   logic [dma_read_pkg::ADDR_W-1:0] addr_d;
   logic [dma_read_pkg::LVL_W-1:0]  max_len_q;
   logic [dma_read_pkg::LVL_W-1:0]  space;
   logic [dma_read_pkg::RLEN_W-1:0] space_ext;
   logic [dma_read_pkg::RLEN_W-1:0] max_len_ext;
   logic [dma_read_pkg::RLEN_W-1:0] burst_len_ext;
   logic [dma_read_pkg::ADDR_W-1:0] burst_bytes;

   // Free words in the FIFO
   assign space = dma_read_pkg::FIFO_DEPTH - fifo_level_i;

   assign space_ext = {{(dma_read_pkg::RLEN_W - dma_read_pkg::LVL_W){1'b0}}, space};
   assign max_len_ext = {{(dma_read_pkg::RLEN_W - dma_read_pkg::LVL_W){1'b0}}, max_len_q};
   assign burst_len_ext = {{(dma_read_pkg::RLEN_W - dma_read_pkg::LVL_W){1'b0}}, burst_len_o};
   assign burst_bytes = {{(dma_read_pkg::ADDR_W - dma_read_pkg::LVL_W){1'b0}}, burst_len_o}
                        * dma_read_pkg::BEAT_BYTES;

   assign busy_o = (state_q == S_WAIT_SPACE);

   always_comb begin
      state_d       = state_q;
      remaining_d   = remaining_o;
      addr_d        = burst_addr_o;
      burst_start_o = 1'b0;
      burst_len_o   = '0;

      case (state_q)
         S_IDLE: begin
            if (start_i) begin
               remaining_d = length_i;
               addr_d      = addr_i;
               state_d     = S_WAIT_SPACE;
            end
         end
         default: begin
            if (!reader_busy_i) begin
               if (remaining_o != '0) begin
                  // Whole remainder if it fits, else a full-size burst
                  if ((remaining_o <= space_ext) && (remaining_o <= max_len_ext)) begin
                     burst_len_o = remaining_o[dma_read_pkg::LVL_W-1:0];
                  end else if (space >= max_len_q) begin
                     burst_len_o = max_len_q;
                  end

                  if (burst_len_o != '0) begin
                     burst_start_o = 1'b1;
                     remaining_d   = remaining_o - burst_len_ext;
                     addr_d        = burst_addr_o + burst_bytes;
                  end
               end else begin
                  state_d = S_IDLE;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q     <= S_IDLE;
         remaining_o <= '0;
      end else begin
         state_q     <= state_d;
         remaining_o <= remaining_d;
      end
   end

   // Burst address and limit captured with the transfer
   always_ff @(posedge clk_i) begin
      burst_addr_o <= addr_d;
      if (state_q == S_IDLE && start_i) begin
         max_len_q <= max_len_i;
      end
   end

   // Each burst takes a nonzero share of the remainder, within the limit
   assert property (@(posedge clk_i) disable iff (reset_i)
      burst_start_o |=> (remaining_o < $past(remaining_o))
                        && ($past(remaining_o) - remaining_o <= max_len_ext));

   // Reserved space covers the whole burst
   assert property (@(posedge clk_i) disable iff (reset_i)
      burst_start_o |=> $past(remaining_o) - remaining_o <= $past(space_ext));

endmodule

/* rtl/dma_read.sv */
module dma_read (
   input  logic                            clk_i,
   input  logic                            reset_i,
   input  logic                            start_i,
   input  logic [dma_read_pkg::ADDR_W-1:0] addr_i,
   input  logic [dma_read_pkg::RLEN_W-1:0] length_i,
   input  logic [dma_read_pkg::LVL_W-1:0]  max_len_i,
   output logic                            busy_o,
   output logic [dma_read_pkg::RLEN_W-1:0] remaining_o,
   output dma_read_pkg::axi_ar_t           ar_o,
   output logic                            ar_valid_o,
   input  logic                            ar_ready_i,
   input  dma_read_pkg::axi_r_t            r_i,
   input  logic                            r_valid_i,
   output logic                            r_ready_o,
   output logic [dma_read_pkg::DATA_W-1:0] m_data_o,
   output logic                            m_valid_o,
   input  logic                            m_ready_i
);

   logic [dma_read_pkg::ADDR_W-1:0] burst_addr;
   logic [dma_read_pkg::LVL_W-1:0]  burst_len;
   logic                            burst_start;
   logic                            reader_busy;

   logic                            fifo_wen;
   logic [dma_read_pkg::DATA_W-1:0] fifo_wdata;
   logic                            fifo_full;
   logic                            fifo_ren;
   logic [dma_read_pkg::DATA_W-1:0] fifo_rdata;
   logic                            fifo_empty;
   logic [dma_read_pkg::LVL_W-1:0]  fifo_level;

   dma_burst_planner planner_inst (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .start_i      (start_i),
      .addr_i       (addr_i),
      .length_i     (length_i),
      .max_len_i    (max_len_i),
      .fifo_level_i (fifo_level),
      .reader_busy_i(reader_busy),
      .burst_start_o(burst_start),
      .burst_addr_o (burst_addr),
      .burst_len_o  (burst_len),
      .busy_o       (busy_o),
      .remaining_o  (remaining_o)
   );

   axi_burst_reader reader_inst (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .burst_start_i(burst_start),
      .burst_addr_i (burst_addr),
      .burst_len_i  (burst_len),
      .busy_o       (reader_busy),
      .ar_o         (ar_o),
      .ar_valid_o   (ar_valid_o),
      .ar_ready_i   (ar_ready_i),
      .r_i          (r_i),
      .r_valid_i    (r_valid_i),
      .r_ready_o    (r_ready_o),
      .fifo_full_i  (fifo_full),
      .fifo_wen_o   (fifo_wen),
      .fifo_wdata_o (fifo_wdata)
   );

   sync_fifo buffer_inst (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .w_en_i   (fifo_wen),
      .w_data_i (fifo_wdata),
      .w_full_o (fifo_full),
      .r_en_i   (fifo_ren),
      .r_data_o (fifo_rdata),
      .r_empty_o(fifo_empty),
      .level_o  (fifo_level)
   );

   fifo_to_stream stream_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .fifo_empty_i(fifo_empty),
      .fifo_rdata_i(fifo_rdata),
      .fifo_read_o (fifo_ren),
      .m_data_o    (m_data_o),
      .m_valid_o   (m_valid_o),
      .m_ready_i   (m_ready_i)
   );

endmodule

/* rtl/dma_read_pkg.sv */
package dma_read_pkg;

   // Data path and address widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 16;

   // FIFO depth is 2**LEN_W, which is also the longest burst
   localparam int LEN_W  = 4;
   localparam int LVL_W  = LEN_W + 1;

   // Transfer length in words
   localparam int RLEN_W = 12;

   localparam logic [LVL_W-1:0] FIFO_DEPTH = LVL_W'(1) << LEN_W;

   // Incrementing 4-byte beats only
   localparam logic [ADDR_W-1:0] BEAT_BYTES = ADDR_W'(4);

   // Read address channel
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;   // beats minus one
   } axi_ar_t;

   // Read data channel
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } axi_r_t;

endpackage

/* rtl/fifo_to_stream.sv */
module fifo_to_stream (
   input  logic                            clk_i,
   input  logic                            reset_i,
   input  logic                            fifo_empty_i,
   input  logic [dma_read_pkg::DATA_W-1:0] fifo_rdata_i,
   output logic                            fifo_read_o,
   output logic [dma_read_pkg::DATA_W-1:0] m_data_o,
   output logic                            m_valid_o,
   input  logic                            m_ready_i
);

   logic pending_q;
   logic load;

   // Word from the last read sits on fifo_rdata_i until loaded
   assign load = pending_q && (!m_valid_o || m_ready_i);

   // Fetch once the pending word has somewhere to go
   assign fifo_read_o = !fifo_empty_i && (!pending_q || load);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         pending_q <= 1'b0;
         m_valid_o <= 1'b0;
      end else begin
         if (fifo_read_o) begin
            pending_q <= 1'b1;
         end else if (load) begin
            pending_q <= 1'b0;
         end

         if (load) begin
            m_valid_o <= 1'b1;
         end else if (m_ready_i) begin
            m_valid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         m_data_o <= fifo_rdata_i;
      end
   end

endmodule

/* rtl/sync_fifo.sv */
module sync_fifo (
   input  logic                            clk_i,
   input  logic                            reset_i,
   input  logic                            w_en_i,
   input  logic [dma_read_pkg::DATA_W-1:0] w_data_i,
   output logic                            w_full_o,
   input  logic                            r_en_i,
   output logic [dma_read_pkg::DATA_W-1:0] r_data_o,
   output logic                            r_empty_o,
   output logic [dma_read_pkg::LVL_W-1:0]  level_o
);

   logic [dma_read_pkg::DATA_W-1:0] mem [0:(1 << dma_read_pkg::LEN_W)-1];
   logic [dma_read_pkg::LEN_W-1:0]  w_ptr_q;
   logic [dma_read_pkg::LEN_W-1:0]  r_ptr_q;
   logic [dma_read_pkg::LVL_W-1:0]  level_q;

   assign level_o   = level_q;
   assign w_full_o  = (level_q == dma_read_pkg::FIFO_DEPTH);
   assign r_empty_o = (level_q == '0);

   // Pointers wrap naturally at the depth
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (w_en_i) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (r_en_i) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         case ({w_en_i, r_en_i})
            2'b10: level_q <= level_q + 1'b1;
            2'b01: level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_ptr_q] <= w_data_i;
      end
   end

   // Registered read, holds until the next read
   always_ff @(posedge clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_ptr_q];
      end
   end

   assert property (@(posedge clk_i) disable iff (reset_i)
      w_en_i |-> !w_full_o);

   assert property (@(posedge clk_i) disable iff (reset_i)
      r_en_i |-> !r_empty_o);

endmodule

/* run.sh */
#!/bin/bash
set -o pipefail
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   -f list.f --top-module tb_dma_read \
   && ./obj_dir/Vtb_dma_read 2>&1 | tee sim.log \
   || { echo "Build or simulation error"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0

/* sim/axi_mem_model.sv */
module axi_mem_model (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic [1:0]            rand_i,
   input  dma_read_pkg::axi_ar_t ar_i,
   input  logic                  ar_valid_i,
   output logic                  ar_ready_o,
   output dma_read_pkg::axi_r_t  r_o,
   output logic                  r_valid_o,
   input  logic                  r_ready_i
);
   timeunit 1ns;
   timeprecision 1ps;

   logic                            active_q;
   logic [dma_read_pkg::ADDR_W-1:0] addr_q;
   logic [dma_read_pkg::LEN_W-1:0]  left_q;

   // Memory image, a function of the byte address
   function automatic logic [31:0] image_word(input logic [15:0] a);
      return {16'h0000, a} ^ 32'h5a5a_0000;
   endfunction

   initial begin
      ar_ready_o = 1'b0;
      r_valid_o  = 1'b0;
      r_o        = '0;
   end

   // rand_i[0] gates AR ready, rand_i[1] gates each R beat
   always @(posedge clk_i) begin
      if (reset_i) begin
         active_q   <= 1'b0;
         ar_ready_o <= 1'b0;
         r_valid_o  <= 1'b0;
      end else if (!active_q) begin
         if (ar_valid_i && ar_ready_o) begin
            active_q   <= 1'b1;
            addr_q     <= ar_i.addr;
            left_q     <= ar_i.len;
            ar_ready_o <= 1'b0;
         end else begin
            ar_ready_o <= rand_i[0];
         end
      end else if (r_valid_o) begin
         if (r_ready_i) begin
            r_valid_o <= 1'b0;
            addr_q    <= addr_q + 16'd4;
            left_q    <= left_q - dma_read_pkg::LEN_W'(1);
            if (r_o.last) begin
               active_q <= 1'b0;
            end
         end
      end else if (rand_i[1]) begin
         r_valid_o <= 1'b1;
         r_o.data  <= image_word(addr_q);
         r_o.last  <= (left_q == '0);
      end
   end

endmodule

/* sim/tb_dma_read.sv */
module tb_dma_read;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD = 100;
   localparam int NUM_TESTS  = 7;

   typedef struct packed {
      logic [dma_read_pkg::ADDR_W-1:0] addr;
      logic [dma_read_pkg::RLEN_W-1:0] words;
      logic [dma_read_pkg::LVL_W-1:0]  max_len;
      logic                            heavy;
   } test_t;

   // Start address, length in words, burst limit, heavy back-pressure
   test_t tests [NUM_TESTS] = '{
      '{16'h0100, 12'd4,  5'd16, 1'b0},
      '{16'h2000, 12'd37, 5'd16, 1'b0},
      '{16'h0ff0, 12'd5,  5'd3,  1'b0},
      '{16'h4444, 12'd6,  5'd1,  1'b0},
      '{16'h0800, 12'd0,  5'd8,  1'b0},
      '{16'h7ffc, 12'd40, 5'd16, 1'b1},
      '{16'h3000, 12'd9,  5'd4,  1'b1}
   };

   logic                            clk_i;
   logic                            reset_i;
   logic                            start_i;
   logic [dma_read_pkg::ADDR_W-1:0] addr_i;
   logic [dma_read_pkg::RLEN_W-1:0] length_i;
   logic [dma_read_pkg::LVL_W-1:0]  max_len_i;
   logic                            busy_o;
   logic [dma_read_pkg::RLEN_W-1:0] remaining_o;
   dma_read_pkg::axi_ar_t           ar_o;
   logic                            ar_valid_o;
   logic                            ar_ready_i;
   dma_read_pkg::axi_r_t            r_i;
   logic                            r_valid_i;
   logic                            r_ready_o;
   logic [dma_read_pkg::DATA_W-1:0] m_data_o;
   logic                            m_valid_o;
   logic                            m_ready_i;

   logic [31:0]                     lfsr_q = 32'h52cc;
   logic [1:0]                      mem_rand;
   logic                            heavy_q;
   test_t                           cur;
   int                              got;
   int                              ar_beats;
   logic [dma_read_pkg::ADDR_W-1:0] next_ar_addr;
   logic                            hold_q;
   logic [dma_read_pkg::DATA_W-1:0] hold_data;
   int                              checks;
   int                              errors;

   dma_read dut0 (.*);

   axi_mem_model mem_model0 (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .rand_i    (mem_rand),
      .ar_i      (ar_o),
      .ar_valid_i(ar_valid_o),
      .ar_ready_o(ar_ready_i),
      .r_o       (r_i),
      .r_valid_o (r_valid_i),
      .r_ready_i (r_ready_o)
   );

   // Galois LFSR, one step per bit
   function automatic logic random_bit();
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      return lfsr_q[0];
   endfunction

   function automatic logic [31:0] mem_word(input logic [15:0] a);
      return {16'h0000, a} ^ 32'h5a5a_0000;
   endfunction

   task automatic check(input logic ok, input string what);
      checks++;
      assert (ok) else begin
         errors++;
         $display("Fail at %0d ns: %s", $time, what);
      end
   endtask

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin : random_drive
      logic r0;
      logic r1;
      logic r2;
      mem_rand <= {random_bit(), random_bit()};
      // Ready one cycle in eight under heavy back-pressure
      if (heavy_q) begin
         r0 = random_bit();
         r1 = random_bit();
         r2 = random_bit();
         m_ready_i <= r0 && r1 && r2;
      end else begin
         m_ready_i <= random_bit();
      end
   end

   always @(negedge clk_i) begin : ar_monitor
      int beats;
      if (!reset_i && ar_valid_o && ar_ready_i) begin
         beats = int'(ar_o.len) + 1;
         check(beats <= int'(cur.max_len) && beats <= 16,
               $sformatf("AR burst of %0d beats, limit %0d", beats, cur.max_len));
         check(ar_o.addr == next_ar_addr,
               $sformatf("AR addr %h, expected %h", ar_o.addr, next_ar_addr));
         ar_beats += beats;
         check(int'(remaining_o) == int'(cur.words) - ar_beats,
               $sformatf("remaining_o %0d after %0d beats", remaining_o, ar_beats));
         next_ar_addr = ar_o.addr + 16'(4 * beats);
      end
   end

   // Space is reserved per burst, so a waiting beat is always taken
   always @(negedge clk_i) begin : r_monitor
      if (!reset_i && r_valid_i) begin
         check(r_ready_o, "r_ready_o low while a read beat waits");
      end
   end

   always @(negedge clk_i) begin : stream_monitor
      logic [15:0] a;
      if (reset_i) begin
         hold_q = 1'b0;
      end else begin
         if (hold_q) begin
            check(m_valid_o && m_data_o == hold_data,
                  $sformatf("stream word %h dropped before it was taken", hold_data));
         end
         if (m_valid_o && m_ready_i) begin
            a = cur.addr + 16'(4 * got);
            check(got < int'(cur.words), $sformatf("extra stream word %h", m_data_o));
            check(m_data_o == mem_word(a),
                  $sformatf("word %0d is %h, expected %h", got, m_data_o, mem_word(a)));
            got++;
         end
         hold_q    = m_valid_o && !m_ready_i;
         hold_data = m_data_o;
      end
   end

   initial begin : watchdog
      int limit;
      limit = 200;
      foreach (tests[i]) begin
         limit += 40 * int'(tests[i].words);
      end
      #(limit * CLK_PERIOD);
      $display("Timeout: transfers did not finish within %0d cycles", limit);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin : stimulus
      int cycles;
      reset_i   = 1'b1;
      start_i   = 1'b0;
      addr_i    = '0;
      length_i  = '0;
      max_len_i = 5'd1;
      m_ready_i = 1'b0;
      heavy_q   = 1'b0;
      cur       = '0;
      checks    = 0;
      errors    = 0;
      repeat (5) @(posedge clk_i);
      reset_i <= 1'b0;
      @(negedge clk_i);
      check(!busy_o, "busy_o high after reset");
      check(!ar_valid_o && !m_valid_o && !r_ready_o,
            "ar_valid_o, m_valid_o or r_ready_o high after reset");

      foreach (tests[t]) begin
         @(posedge clk_i);
         cur          = tests[t];
         got          = 0;
         ar_beats     = 0;
         next_ar_addr = tests[t].addr;
         heavy_q   <= tests[t].heavy;
         start_i   <= 1'b1;
         addr_i    <= tests[t].addr;
         length_i  <= tests[t].words;
         max_len_i <= tests[t].max_len;
         @(posedge clk_i);
         start_i <= 1'b0;
         @(negedge clk_i);
         check(busy_o, $sformatf("busy_o low after start of transfer %0d", t));
         cycles = 0;
         while (busy_o || got < int'(cur.words)) begin
            @(negedge clk_i);
            cycles++;
         end
         check(remaining_o == '0, $sformatf("remaining_o %0d at end", remaining_o));
         check(ar_beats == int'(cur.words),
               $sformatf("bursts sum to %0d beats, expected %0d", ar_beats, cur.words));
         if (cur.words == '0) begin
            check(cycles <= 3, $sformatf("zero-length busy for %0d cycles", cycles));
         end
      end

      // Catch stray words after the last transfer
      repeat (8) @(posedge clk_i);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
